//--- eeprom_bit_engine.sv
`timescale 1ns/100ps

`include "eeprom_params.svh"

module eeprom_bit_engine (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  eeprom_bus_pkg::bit_cmd_t  cmd,
    input  eeprom_host_pkg::ee_byte_t cmd_byte,
    input  logic                      cmd_last,
    output logic                      done,
    output logic                      ack_ok,
    output eeprom_host_pkg::ee_byte_t rx_byte,
    output logic                      scl,
    output logic                      sda_oe,
    input  logic                      sda_in
);

    localparam int HALF = `EE_SCL_HALF;

    eeprom_bus_pkg::bit_state_t state;

    logic [7:0]                div_cnt;
    logic                      tick;    // last cycle of a half period
    logic                      mid;     // SDA update or sample point
    logic                      hi;      // 1 in the SCL high half
    logic [2:0]                bit_cnt;
    logic                      rd;
    logic                      last;
    logic                      scl_r;
    logic                      sda_oe_r;
    logic                      done_r;
    eeprom_host_pkg::ee_byte_t shreg;

    assign tick      = (div_cnt == 8'(HALF - 1));
    assign mid       = (div_cnt == 8'(HALF / 2));
    assign cmd_ready = (state == eeprom_bus_pkg::B_IDLE);
    assign scl       = scl_r;
    assign sda_oe    = sda_oe_r;
    assign done      = done_r;
    assign rx_byte   = shreg;

    // write bits echo back from the line, read bits come from the slave
    always_ff @(posedge CLK)
    begin
        if (state == eeprom_bus_pkg::B_IDLE && cmd_valid)
            shreg <= cmd_byte;
        else if (state == eeprom_bus_pkg::B_SHIFT && hi && mid)
            shreg <= {shreg[6:0], sda_in};
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_bus_pkg::B_IDLE;
            div_cnt  <= '0;
            hi       <= 1'b0;
            bit_cnt  <= '0;
            rd       <= 1'b0;
            last     <= 1'b0;
            scl_r    <= 1'b1;   // bus idle
            sda_oe_r <= 1'b0;
            done_r   <= 1'b0;
            ack_ok   <= 1'b0;
        end
        else
        begin
            done_r <= 1'b0;

            if (state != eeprom_bus_pkg::B_IDLE)
            begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick)
                begin
                    hi    <= ~hi;
                    scl_r <= ~hi;
                end
            end

            case (state)
                eeprom_bus_pkg::B_IDLE:
                    if (cmd_valid)
                    begin
                        div_cnt <= '0;
                        hi      <= 1'b0;
                        bit_cnt <= '0;
                        rd      <= (cmd == eeprom_bus_pkg::CMD_READ);
                        last    <= cmd_last;
                        scl_r   <= 1'b0;    // every command opens with a low half
                        case (cmd)
                            eeprom_bus_pkg::CMD_START: state <= eeprom_bus_pkg::B_START;
                            eeprom_bus_pkg::CMD_STOP:  state <= eeprom_bus_pkg::B_STOP;
                            default:                   state <= eeprom_bus_pkg::B_SHIFT;
                        endcase
                    end
                eeprom_bus_pkg::B_START:
                begin
                    if (mid)
                        sda_oe_r <= hi;     // release, then pull low with SCL high
                    if (hi && tick)
                    begin
                        state  <= eeprom_bus_pkg::B_IDLE;
                        done_r <= 1'b1;
                    end
                end
                eeprom_bus_pkg::B_STOP:
                begin
                    if (mid)
                        sda_oe_r <= ~hi;    // hold low, then release with SCL high
                    if (hi && tick)
                    begin
                        scl_r  <= 1'b1;
                        state  <= eeprom_bus_pkg::B_IDLE;
                        done_r <= 1'b1;
                    end
                end
                eeprom_bus_pkg::B_SHIFT:
                begin
                    if (!hi && mid)
                        sda_oe_r <= rd ? 1'b0 : ~shreg[7];  // MSB first
                    if (hi && tick)
                    begin
                        if (bit_cnt == 3'd7)
                            state <= eeprom_bus_pkg::B_ACK;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                eeprom_bus_pkg::B_ACK:
                begin
                    if (!hi && mid)
                        sda_oe_r <= rd && !last;
                    if (hi && mid && !rd)
                        ack_ok <= ~sda_in;
                    if (hi && tick)
                    begin
                        state  <= eeprom_bus_pkg::B_IDLE;
                        done_r <= 1'b1;
                    end
                end
                default:
                    state <= eeprom_bus_pkg::B_IDLE;
            endcase
        end
    end

endmodule

//--- eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    // commands from sequencer to bit engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,   // byte out, then sample ack
        CMD_READ  = 2'd3    // byte in, then send ack or nack
    } bit_cmd_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_WR,
        S_ADDR,
        S_DATA,
        S_RESTART,
        S_CTRL_RD,
        S_READ,
        S_STOP,
        S_RESPOND
    } seq_state_t;

    typedef enum logic [2:0] {
        B_IDLE,
        B_START,
        B_SHIFT,
        B_ACK,
        B_STOP
    } bit_state_t;

endpackage

//--- eeprom_cases.txt
# name  op (0 write, 1 read)  addr  data  mute  exp_data  exp_nack
# addr, data and exp_data are hex, the rest decimal
wr_blk0 0 005 3c 0 00 0
rd_blk0 1 005 00 0 3c 0
wr_blk1 0 1a2 5a 0 00 0
rd_blk1 1 1a2 00 0 5a 0
wr_blk2 0 2ff c3 0 00 0
rd_blk2 1 2ff 00 0 c3 0
wr_blk3 0 310 01 0 00 0
rd_blk3 1 310 00 0 01 0
wr_blk4 0 480 80 0 00 0
rd_blk4 1 480 00 0 80 0
wr_blk5 0 57e e7 0 00 0
rd_blk5 1 57e 00 0 e7 0
wr_blk6 0 600 96 0 00 0
rd_blk6 1 600 00 0 96 0
wr_blk7 0 7c4 4b 0 00 0
rd_blk7 1 7c4 00 0 4b 0
fill_blk0 1 0f0 00 0 e5 0
fill_blk7 1 7ab 00 0 5e 0
mute_wr 0 005 ff 1 00 1
rd_after_mute 1 005 00 0 3c 0
mute_rd 1 0f0 00 1 00 1
rd_unmuted 1 0f0 00 0 e5 0

//--- eeprom_ctrl_sva.sv
`timescale 1ns/100ps

module eeprom_ctrl_sva (
    input logic                       CLK,
    input logic                       RESET,
    input logic                       req_valid,
    input logic                       req_ready,
    input logic                       req_read,
    input eeprom_host_pkg::ee_addr_t  req_addr,
    input eeprom_host_pkg::ee_byte_t  req_data,
    input logic                       rsp_valid,
    input logic                       rsp_ready,
    input eeprom_host_pkg::ee_byte_t  rsp_data,
    input logic                       rsp_nack,
    input logic                       scl,
    input logic                       sda_oe,
    input eeprom_bus_pkg::bit_state_t bit_state
);

    req_hold: assert property (@(posedge CLK) disable iff (RESET)
        req_valid && !req_ready |=> req_valid && $stable(req_read)
                                    && $stable(req_addr) && $stable(req_data))
        else $error("request payload moved while stalled");

    rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_nack))
        else $error("response dropped or moved while stalled");

    // only start and stop may move SDA with SCL high
    sda_with_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        !$stable(sda_oe) && scl |-> bit_state == eeprom_bus_pkg::B_START
                                    || bit_state == eeprom_bus_pkg::B_STOP)
        else $error("sda_oe changed while scl high outside start or stop");

    reset_quiet: assert property (@(posedge CLK) RESET |=> !rsp_valid)
        else $error("rsp_valid high during reset");

endmodule

//--- eeprom_ctrl_top.sv
`timescale 1ns/100ps

module eeprom_ctrl_top (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_read,
    input  eeprom_host_pkg::ee_addr_t req_addr,
    input  eeprom_host_pkg::ee_byte_t req_data,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output eeprom_host_pkg::ee_byte_t rsp_data,
    output logic                      rsp_nack,
    output logic                      scl,
    output logic                      sda_oe,
    input  logic                      sda_in
);

    // buffer to sequencer
    logic                      q_valid;
    logic                      q_ready;
    logic                      q_read;
    eeprom_host_pkg::ee_addr_t q_addr;
    eeprom_host_pkg::ee_byte_t q_data;

    // sequencer to bit engine
    logic                      cmd_valid;
    logic                      cmd_ready;
    eeprom_bus_pkg::bit_cmd_t  cmd;
    eeprom_host_pkg::ee_byte_t cmd_byte;
    logic                      cmd_last;
    logic                      done;
    logic                      ack_ok;
    eeprom_host_pkg::ee_byte_t rx_byte;

    eeprom_req_buffer u_buffer (.*);

    eeprom_sequencer u_sequencer (.*);

    eeprom_bit_engine u_bit_engine (.*);

endmodule

//--- eeprom_host_pkg.sv
package eeprom_host_pkg;

    // byte address with block select in the top 3 bits
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0] ee_byte_t;      // data byte, host side and bus side

endpackage

//--- eeprom_params.svh
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// device type code for serial EEPROMs
// forms the high nibble of every control byte
`define EE_DEVICE_CODE 4'b1010

// CLK cycles per SCL half period
`define EE_SCL_HALF 4

`define EE_REQ_DEPTH 2      // request buffer entries

`endif

//--- eeprom_req_buffer.sv
`timescale 1ns/100ps

`include "eeprom_params.svh"

module eeprom_req_buffer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_read,
    input  eeprom_host_pkg::ee_addr_t req_addr,
    input  eeprom_host_pkg::ee_byte_t req_data,
    output logic                      q_valid,
    input  logic                      q_ready,
    output logic                      q_read,
    output eeprom_host_pkg::ee_addr_t q_addr,
    output eeprom_host_pkg::ee_byte_t q_data
);

    localparam int DEPTH = `EE_REQ_DEPTH;
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic                      mem_read [DEPTH];
    eeprom_host_pkg::ee_addr_t mem_addr [DEPTH];
    eeprom_host_pkg::ee_byte_t mem_data [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign req_ready = (count != CW'(DEPTH));
    assign q_valid   = (count != '0);
    assign push      = req_valid && req_ready;
    assign pop       = q_valid && q_ready;

    // head entry straight from storage
    assign q_read = mem_read[rd_ptr];
    assign q_addr = mem_addr[rd_ptr];
    assign q_data = mem_data[rd_ptr];

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            mem_read[wr_ptr] <= req_read;
            mem_addr[wr_ptr] <= req_addr;
            mem_data[wr_ptr] <= req_data;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // none, or both at once
            endcase
        end
    end

endmodule

//--- eeprom_sequencer.sv
`timescale 1ns/100ps

`include "eeprom_params.svh"

module eeprom_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      q_valid,
    output logic                      q_ready,
    input  logic                      q_read,
    input  eeprom_host_pkg::ee_addr_t q_addr,
    input  eeprom_host_pkg::ee_byte_t q_data,
    output logic                      cmd_valid,
    input  logic                      cmd_ready,
    output eeprom_bus_pkg::bit_cmd_t  cmd,
    output eeprom_host_pkg::ee_byte_t cmd_byte,
    output logic                      cmd_last,
    input  logic                      done,
    input  logic                      ack_ok,
    input  eeprom_host_pkg::ee_byte_t rx_byte,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output eeprom_host_pkg::ee_byte_t rsp_data,
    output logic                      rsp_nack
);

    eeprom_bus_pkg::seq_state_t state;

    logic                      issued;      // command taken, waiting for done
    logic                      cmd_active;
    logic                      cmd_done;
    logic                      ack_fail;
    logic                      nack;
    logic                      lat_read;
    eeprom_host_pkg::ee_addr_t lat_addr;
    eeprom_host_pkg::ee_byte_t lat_data;
    eeprom_host_pkg::ee_byte_t rdata;

    assign q_ready   = (state == eeprom_bus_pkg::S_IDLE);
    assign rsp_valid = (state == eeprom_bus_pkg::S_RESPOND);
    assign rsp_data  = rdata;
    assign rsp_nack  = nack;
    assign cmd_valid = cmd_active && !issued;
    assign cmd_last  = (state == eeprom_bus_pkg::S_READ);   // single byte read ends with nack
    assign cmd_done  = issued && done;
    assign ack_fail  = cmd_done && !ack_ok;

    // command list per state
    always_comb
    begin
        cmd        = eeprom_bus_pkg::CMD_START;
        cmd_byte   = '0;
        cmd_active = 1'b1;
        case (state)
            eeprom_bus_pkg::S_START,
            eeprom_bus_pkg::S_RESTART:
                cmd = eeprom_bus_pkg::CMD_START;
            eeprom_bus_pkg::S_CTRL_WR:
            begin
                cmd      = eeprom_bus_pkg::CMD_WRITE;
                cmd_byte = {`EE_DEVICE_CODE, lat_addr[10:8], 1'b0};
            end
            eeprom_bus_pkg::S_ADDR:
            begin
                cmd      = eeprom_bus_pkg::CMD_WRITE;
                cmd_byte = lat_addr[7:0];
            end
            eeprom_bus_pkg::S_DATA:
            begin
                cmd      = eeprom_bus_pkg::CMD_WRITE;
                cmd_byte = lat_data;
            end
            eeprom_bus_pkg::S_CTRL_RD:
            begin
                cmd      = eeprom_bus_pkg::CMD_WRITE;
                cmd_byte = {`EE_DEVICE_CODE, lat_addr[10:8], 1'b1};
            end
            eeprom_bus_pkg::S_READ:
                cmd = eeprom_bus_pkg::CMD_READ;
            eeprom_bus_pkg::S_STOP:
                cmd = eeprom_bus_pkg::CMD_STOP;
            default:
                cmd_active = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_bus_pkg::S_IDLE && q_valid)
        begin
            lat_read <= q_read;
            lat_addr <= q_addr;
            lat_data <= q_data;
            rdata    <= '0;     // writes and failed reads answer zero
        end
        else if (state == eeprom_bus_pkg::S_READ && cmd_done)
            rdata <= rx_byte;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= eeprom_bus_pkg::S_IDLE;
            issued <= 1'b0;
            nack   <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                issued <= 1'b1;
            else if (cmd_done)
                issued <= 1'b0;

            if (ack_fail && cmd == eeprom_bus_pkg::CMD_WRITE)    // only written bytes get an ack
                nack <= 1'b1;

            case (state)
                eeprom_bus_pkg::S_IDLE:
                    if (q_valid)
                    begin
                        nack  <= 1'b0;
                        state <= eeprom_bus_pkg::S_START;
                    end
                eeprom_bus_pkg::S_START:
                    if (cmd_done)
                        state <= eeprom_bus_pkg::S_CTRL_WR;
                eeprom_bus_pkg::S_CTRL_WR:
                    if (ack_fail)
                        state <= eeprom_bus_pkg::S_STOP;
                    else if (cmd_done)
                        state <= eeprom_bus_pkg::S_ADDR;
                eeprom_bus_pkg::S_ADDR:
                    if (ack_fail)
                        state <= eeprom_bus_pkg::S_STOP;
                    else if (cmd_done)
                        state <= lat_read ? eeprom_bus_pkg::S_RESTART
                                          : eeprom_bus_pkg::S_DATA;
                eeprom_bus_pkg::S_DATA:
                    if (cmd_done)
                        state <= eeprom_bus_pkg::S_STOP;    // nack flagged above
                eeprom_bus_pkg::S_RESTART:
                    if (cmd_done)
                        state <= eeprom_bus_pkg::S_CTRL_RD;
                eeprom_bus_pkg::S_CTRL_RD:
                    if (ack_fail)
                        state <= eeprom_bus_pkg::S_STOP;
                    else if (cmd_done)
                        state <= eeprom_bus_pkg::S_READ;
                eeprom_bus_pkg::S_READ:
                    if (cmd_done)
                        state <= eeprom_bus_pkg::S_STOP;
                eeprom_bus_pkg::S_STOP:
                    if (cmd_done)
                        state <= eeprom_bus_pkg::S_RESPOND;
                eeprom_bus_pkg::S_RESPOND:
                    if (rsp_ready)
                        state <= eeprom_bus_pkg::S_IDLE;
                default:
                    state <= eeprom_bus_pkg::S_IDLE;
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_eeprom_ctrl \
    -Mdir obj_dir -o sim_eeprom_ctrl

sim_out=$(./obj_dir/sim_eeprom_ctrl)
echo "$sim_out"

if grep -qx "Test completed successfully" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

//--- sim.f
+incdir+.
eeprom_host_pkg.sv
eeprom_bus_pkg.sv
eeprom_req_buffer.sv
eeprom_sequencer.sv
eeprom_bit_engine.sv
eeprom_ctrl_top.sv
eeprom_ctrl_sva.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

//--- tb_eeprom_ctrl.sv
`timescale 1ns/100ps

`include "eeprom_params.svh"

module tb_eeprom_ctrl;

    logic                      CLK;
    logic                      RESET;
    logic                      req_valid;
    logic                      req_ready;
    logic                      req_read;
    eeprom_host_pkg::ee_addr_t req_addr;
    eeprom_host_pkg::ee_byte_t req_data;
    logic                      rsp_valid;
    logic                      rsp_ready;
    eeprom_host_pkg::ee_byte_t rsp_data;
    logic                      rsp_nack;
    logic                      scl;
    logic                      sda_oe;
    logic                      model_pull;
    logic                      mute;
    wire                       sda;

    string      c_name [$];
    int         c_op [$];
    int         c_addr [$];
    int         c_data [$];
    int         c_mute [$];
    int         c_exp [$];
    int         c_nack [$];
    int         exp_idx [$];
    logic [7:0] exp_data [$];
    logic       exp_nack [$];
    logic [7:0] ref_mem [2048];
    bit         ref_ok [2048];
    logic [31:0] lfsr;
    int         cycles;
    int         limit;
    int         n_pass;
    int         n_fail;
    int         n_err;

    assign sda = !(sda_oe || model_pull);   // open drain with pull-up

    eeprom_ctrl_top uut (
        .CLK(CLK), .RESET(RESET),
        .req_valid(req_valid), .req_ready(req_ready), .req_read(req_read),
        .req_addr(req_addr), .req_data(req_data),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
        .rsp_data(rsp_data), .rsp_nack(rsp_nack),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    tb_eeprom_model model (.scl(scl), .sda(sda), .mute(mute), .sda_pull(model_pull));

    bind eeprom_ctrl_top eeprom_ctrl_sva u_sva (.*, .bit_state(u_bit_engine.state));

    initial
        CLK = 1'b0;
    always #4 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (limit != 0 && cycles > limit)
        begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        string nm;
        int    op;
        int    a;
        int    d;
        int    m;
        int    e;
        int    k;
        fd = $fopen("eeprom_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open eeprom_cases.txt");
            n_err++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != 8'h23)     // skip comment lines
            begin
                n = $sscanf(line, "%s %d %h %h %d %h %d", nm, op, a, d, m, e, k);
                if (n == 7)
                begin
                    c_name.push_back(nm);
                    c_op.push_back(op);
                    c_addr.push_back(a);
                    c_data.push_back(d);
                    c_mute.push_back(m);
                    c_exp.push_back(e);
                    c_nack.push_back(k);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_request(input int i);
        int         waited;
        logic [7:0] ed;
        logic       en;
        waited    = 0;
        req_valid = 1'b1;
        req_read  = (c_op[i] == 1);
        req_addr  = c_addr[i][10:0];
        req_data  = c_data[i][7:0];
        while (!req_ready)
        begin
            waited++;
            @(posedge CLK);
            #1;
        end
        @(posedge CLK);     // transfer edge
        if (i < 2 && waited != 0)
        begin
            $display("request %s waited %0d cycles although the buffer had room",
                     c_name[i], waited);
            n_err++;
        end
        // expected response from the device rules and the reference memory
        en = c_mute[i][0];
        ed = 8'h00;
        if (c_mute[i] == 0 && c_op[i] == 0)
        begin
            ref_mem[c_addr[i]] = c_data[i][7:0];
            ref_ok[c_addr[i]]  = 1'b1;
        end
        else if (c_mute[i] == 0)
            ed = ref_ok[c_addr[i]] ? ref_mem[c_addr[i]] : c_exp[i][7:0];
        if (ed != c_exp[i][7:0] || en != c_nack[i][0])
        begin
            $display("cases file and reference memory disagree for %s", c_name[i]);
            n_err++;
        end
        exp_idx.push_back(i);
        exp_data.push_back(ed);
        exp_nack.push_back(en);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drive_all();
        for (int i = 0; i < c_name.size(); i++)
        begin
            if (c_mute[i][0] != mute)
            begin
                while (exp_idx.size() != 0)     // bus idle before the model changes
                begin
                    @(posedge CLK);
                    #1;
                end
                mute = c_mute[i][0];
            end
            send_request(i);
        end
    endtask

    task automatic collect_all();
        int         got;
        int         idx;
        logic [7:0] ed;
        logic       en;
        got = 0;
        while (got < c_name.size())
        begin
            @(posedge CLK);
            #1;
            rsp_ready = lfsr[0];    // random stall
            lfsr      = lfsr_step(lfsr);
            if (rsp_valid && rsp_ready)     // taken at the next edge
            begin
                if (exp_idx.size() == 0)
                begin
                    $display("response arrived with no request outstanding");
                    n_err++;
                end
                else
                begin
                    idx = exp_idx.pop_front();
                    ed  = exp_data.pop_front();
                    en  = exp_nack.pop_front();
                    got++;
                    if (rsp_data !== ed || rsp_nack !== en)
                    begin
                        $display("Fail %s: expected %02h nack %0d, actual %02h nack %0d",
                                 c_name[idx], ed, en, rsp_data, rsp_nack);
                        n_fail++;
                    end
                    else
                    begin
                        $display("pass %s: data %02h nack %0d", c_name[idx], ed, en);
                        n_pass++;
                    end
                end
            end
        end
    endtask

    initial
    begin
        RESET     = 1'b1;
        req_valid = 1'b0;
        req_read  = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        rsp_ready = 1'b0;
        mute      = 1'b0;
        lfsr      = 32'hc632_3da7;
        cycles    = 0;
        limit     = 0;
        n_pass    = 0;
        n_fail    = 0;
        n_err     = 0;
        load_cases();
        // longest transaction is a read of about 39 SCL periods
        limit = (c_name.size() + 1) * (44 * 2 * `EE_SCL_HALF + 16) + 100;
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(posedge CLK);
        #1;
        if (scl !== 1'b1 || sda_oe !== 1'b0 || rsp_valid !== 1'b0 || req_ready !== 1'b1)
        begin
            $display("Fail reset_state: expected scl sda_oe rsp_valid req_ready %b, actual %b",
                     4'b1001, {scl, sda_oe, rsp_valid, req_ready});
            n_fail++;
        end
        else
        begin
            $display("pass reset_state");
            n_pass++;
        end
        fork
            drive_all();
            collect_all();
        join
        repeat (44 * 2 * `EE_SCL_HALF + 16)     // one more transaction length
        begin
            @(posedge CLK);
            #1;
            if (rsp_valid)
            begin
                $display("extra response after the last request");
                n_err++;
            end
        end
        $display("tests %0d  passed %0d  failed %0d  other errors %0d",
                 n_pass + n_fail, n_pass, n_fail, n_err);
        if (n_fail == 0 && n_err == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- tb_eeprom_model.sv
`timescale 1ns/100ps

module tb_eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic mute,
    output logic sda_pull
);

    logic [7:0]  mem [2048];
    logic [7:0]  shreg;
    logic [7:0]  tx;
    logic [2:0]  blk;
    logic [10:0] ptr;
    int          bit_cnt;
    int          byte_idx;
    logic        active;
    logic        reading;
    logic        rd_pend;
    logic        rd_done;
    logic        acked;

    function automatic logic [7:0] fill(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], 5'b10101};
    endfunction

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = fill(11'(i));
        sda_pull = 1'b0;
        active   = 1'b0;
        reading  = 1'b0;
        rd_pend  = 1'b0;
        rd_done  = 1'b0;
        bit_cnt  = 0;
        byte_idx = 0;
        ptr      = '0;
        blk      = '0;
    end

    task automatic take_byte();
        acked = !mute;
        case (byte_idx)
            0:
            begin
                if (shreg[7:4] != 4'b1010)
                    acked = 1'b0;
                blk = shreg[3:1];
                if (shreg[0])
                    rd_pend = acked;    // read starts after this ack
            end
            1:
                ptr = {blk, shreg};
            default:
                if (acked)
                begin
                    mem[ptr] = shreg;
                    ptr      = ptr + 11'd1;
                end
        endcase
        byte_idx++;
    endtask

    always @(negedge sda)
    begin
        if (scl)    // start or repeated start
        begin
            active   = 1'b1;
            bit_cnt  = 0;
            byte_idx = 0;
            reading  = 1'b0;
            rd_pend  = 1'b0;
            rd_done  = 1'b0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl)
        begin
            active   = 1'b0;    // stop
            reading  = 1'b0;
            sda_pull = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active)
        begin
            if (bit_cnt < 8)
            begin
                if (!reading)
                    shreg = {shreg[6:0], sda};
                bit_cnt++;
            end
            else
            begin
                if (reading && sda)
                    rd_done = 1'b1;     // master nack
                bit_cnt = 9;
            end
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (bit_cnt == 8)
            begin
                if (reading)
                    sda_pull = 1'b0;
                else
                begin
                    take_byte();
                    sda_pull = acked;
                end
            end
            else if (bit_cnt == 9)
            begin
                sda_pull = 1'b0;
                bit_cnt  = 0;
                if (rd_pend)
                begin
                    reading = 1'b1;
                    rd_pend = 1'b0;
                end
                if (reading && !rd_done)
                begin
                    tx       = mem[ptr];
                    ptr      = ptr + 11'd1;
                    sda_pull = !tx[7];
                end
            end
            else if (reading && bit_cnt > 0)
                sda_pull = !tx[3'(7 - bit_cnt)];
        end
    end

endmodule
